//--- src/fft2d_pkg.sv
package fft2d_pkg;

  // sample and frame geometry
  localparam int SAMPLE_W    = 16;            // bits per real or imag part
  localparam int PTS         = 4;             // points per transform
  localparam int FRAME_LEN   = PTS * PTS;     // 4x4 complex frame

  // counter widths
  localparam int PTS_CNT_W   = 2;             // index inside one block of four
  localparam int FRAME_CNT_W = 4;             // index inside one frame

  // scaling per 1-D transform
  localparam int SCALE_SHIFT = 2;             // divide by 4
  localparam int SUM_W       = SAMPLE_W + 2;  // headroom for the four-way sum

  // one complex sample
  // im sits in the upper half and re in the lower half of the 32-bit word
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] im;           // imag part
    logic signed [SAMPLE_W-1:0] re;           // real part
  } cplx_t;

  // corner-turn phases
  typedef enum logic {
    CT_FILL  = 1'b0,                          // taking rows in
    CT_DRAIN = 1'b1                           // sending columns out
  } ct_state_e;

endpackage

//--- src/fft4_stage.sv
`timescale 1ns/10ps

module fft4_stage import fft2d_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  // sample stream in
  input  cplx_t in_data_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  // result stream out
  output cplx_t out_data_o,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output logic  out_last_o
);

  logic [PTS_CNT_W-1:0] gath_cnt_q;           // samples taken in current block
  logic [PTS_CNT_W-1:0] out_cnt_q;            // result index being sent
  logic                 out_valid_q;          // output register holds a block

  cplx_t gath_q [0:PTS-2];                    // a, b, c once three are in
  cplx_t res_q  [0:PTS-1];                    // X0..X3 waiting to go out
  cplx_t bfly   [0:PTS-1];                    // butterfly results, comb

  logic in_acc;                               // input beat this cycle
  logic blk_load;                             // fourth sample taken, load results
  logic out_acc;                              // output beat this cycle
  logic out_final;                            // X3 leaving this cycle

  // partial sums and differences at SUM_W
  logic signed [SUM_W-1:0] s_ac_re, s_ac_im;  // a + c
  logic signed [SUM_W-1:0] s_bd_re, s_bd_im;  // b + d
  logic signed [SUM_W-1:0] d_ac_re, d_ac_im;  // a - c
  logic signed [SUM_W-1:0] d_bd_re, d_bd_im;  // b - d

  // arithmetic shift then drop the headroom bits
  function automatic logic signed [SAMPLE_W-1:0] scale(input logic signed [SUM_W-1:0] s);
    logic signed [SUM_W-1:0] t;
    t = s >>> SCALE_SHIFT;                    // rounds toward minus infinity
    return t[SAMPLE_W-1:0];
  endfunction

  assign out_acc   = out_valid_q && out_ready_i;
  assign out_final = out_acc && (out_cnt_q == PTS_CNT_W'(PTS - 1));

  // fourth sample may only enter when the result register frees up
  assign in_ready_o = (gath_cnt_q != PTS_CNT_W'(PTS - 1)) || !out_valid_q || out_final;
  assign in_acc     = in_valid_i && in_ready_o;
  assign blk_load   = in_acc && (gath_cnt_q == PTS_CNT_W'(PTS - 1));

  // radix-4 butterfly, d comes straight from the input port
  always_comb
  begin
    s_ac_re = gath_q[0].re + gath_q[2].re;
    s_ac_im = gath_q[0].im + gath_q[2].im;
    d_ac_re = gath_q[0].re - gath_q[2].re;
    d_ac_im = gath_q[0].im - gath_q[2].im;
    s_bd_re = gath_q[1].re + in_data_i.re;
    s_bd_im = gath_q[1].im + in_data_i.im;
    d_bd_re = gath_q[1].re - in_data_i.re;
    d_bd_im = gath_q[1].im - in_data_i.im;

    bfly[0].re = scale(s_ac_re + s_bd_re);    // X0 = a+b+c+d
    bfly[0].im = scale(s_ac_im + s_bd_im);
    bfly[1].re = scale(d_ac_re + d_bd_im);    // X1 = (a-c) - j(b-d)
    bfly[1].im = scale(d_ac_im - d_bd_re);
    bfly[2].re = scale(s_ac_re - s_bd_re);    // X2 = a-b+c-d
    bfly[2].im = scale(s_ac_im - s_bd_im);
    bfly[3].re = scale(d_ac_re - d_bd_im);    // X3 = (a-c) + j(b-d)
    bfly[3].im = scale(d_ac_im + d_bd_re);
  end

  // gather and output counters run independently
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      gath_cnt_q  <= '0;
      out_cnt_q   <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (in_acc)
        gath_cnt_q <= gath_cnt_q + 1'b1;      // wraps after the fourth
      if (out_acc)
        out_cnt_q <= out_cnt_q + 1'b1;        // back to X0 after X3
      if (blk_load)
        out_valid_q <= 1'b1;                  // new block takes over directly
      else if (out_final)
        out_valid_q <= 1'b0;
    end
  end

  // sample and result storage
  always_ff @(posedge clk)
  begin
    if (in_acc)
    begin
      gath_q[2] <= in_data_i;                 // shift in, oldest ends at [0]
      gath_q[1] <= gath_q[2];
      gath_q[0] <= gath_q[1];
    end
    if (blk_load)
      res_q <= bfly;
  end

  assign out_data_o  = res_q[out_cnt_q];
  assign out_valid_o = out_valid_q;
  assign out_last_o  = (out_cnt_q == PTS_CNT_W'(PTS - 1));  // flags X3

endmodule

//--- src/corner_turn_buffer.sv
`timescale 1ns/10ps

module corner_turn_buffer import fft2d_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  // row-major stream in
  input  cplx_t in_data_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  // column-major stream out
  output cplx_t out_data_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  ct_state_e state_q;                         // fill or drain

  cplx_t mem [0:FRAME_LEN-1];                 // one full frame, row-major
  cplx_t out_data_q;                          // registered read data

  logic [FRAME_CNT_W-1:0] wr_cnt_q;           // write address, k = row*4 + col
  logic [FRAME_CNT_W-1:0] rd_cnt_q;           // read order, col outer row inner
  logic [FRAME_CNT_W-1:0] rd_addr;            // rd_cnt_q remapped to row-major
  logic                   rd_busy_q;          // reads left to issue
  logic                   out_valid_q;        // out_data_q holds an entry

  logic wr_en;                                // input beat this cycle
  logic rd_adv;                               // issue next read
  logic out_acc;                              // output beat this cycle

  assign in_ready_o = (state_q == CT_FILL);   // no writes during drain
  assign wr_en      = in_valid_i && in_ready_o;
  assign out_acc    = out_valid_q && out_ready_i;

  // refill the read register when it is empty or being emptied
  assign rd_adv = rd_busy_q && (!out_valid_q || out_ready_i);

  // swap row and column fields of the count
  assign rd_addr = {rd_cnt_q[PTS_CNT_W-1:0], rd_cnt_q[FRAME_CNT_W-1:PTS_CNT_W]};

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= CT_FILL;
      wr_cnt_q    <= '0;
      rd_cnt_q    <= '0;
      rd_busy_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        CT_FILL:
        begin
          if (wr_en)
          begin
            wr_cnt_q <= wr_cnt_q + 1'b1;      // wraps to 0 for the next frame
            if (wr_cnt_q == FRAME_CNT_W'(FRAME_LEN - 1))
            begin
              state_q   <= CT_DRAIN;          // frame complete
              rd_busy_q <= 1'b1;
            end
          end
        end
        CT_DRAIN:
        begin
          // all reads issued and the last one is taken
          if (!rd_busy_q && out_acc)
            state_q <= CT_FILL;
        end
        default:
          state_q <= CT_FILL;
      endcase

      if (rd_adv)
      begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        if (rd_cnt_q == FRAME_CNT_W'(FRAME_LEN - 1))
          rd_busy_q <= 1'b0;                  // sixteenth read issued
      end

      if (rd_adv)
        out_valid_q <= 1'b1;
      else if (out_acc)
        out_valid_q <= 1'b0;
    end
  end

  // frame storage and read port
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_cnt_q] <= in_data_i;
    if (rd_adv)
      out_data_q <= mem[rd_addr];             // held while stalled
  end

  assign out_data_o  = out_data_q;
  assign out_valid_o = out_valid_q;

endmodule

//--- src/fft2d_top.sv
`timescale 1ns/10ps

module fft2d_top import fft2d_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  // input sample stream, row-major
  input  cplx_t s_data_i,
  input  logic  s_valid_i,
  output logic  s_ready_o,
  // 2-D result stream, column-major
  output cplx_t m_data_o,
  output logic  m_valid_o,
  input  logic  m_ready_i,
  output logic  m_last_o
);

  cplx_t row_data;                            // row FFT results
  logic  row_valid;
  logic  row_ready;

  cplx_t ct_data;                             // transposed row results
  logic  ct_valid;
  logic  ct_ready;

  // 4-point FFT along each row
  fft4_stage i_row_fft (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_data_i   (s_data_i),
    .in_valid_i  (s_valid_i),
    .in_ready_o  (s_ready_o),
    .out_data_o  (row_data),
    .out_valid_o (row_valid),
    .out_ready_i (row_ready),
    .out_last_o  ()                           // buffer counts positions itself
  );

  // rows in, columns out
  corner_turn_buffer i_corner_turn (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_data_i   (row_data),
    .in_valid_i  (row_valid),
    .in_ready_o  (row_ready),
    .out_data_o  (ct_data),
    .out_valid_o (ct_valid),
    .out_ready_i (ct_ready)
  );

  // 4-point FFT along each column, last marks column end
  fft4_stage i_col_fft (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_data_i   (ct_data),
    .in_valid_i  (ct_valid),
    .in_ready_o  (ct_ready),
    .out_data_o  (m_data_o),
    .out_valid_o (m_valid_o),
    .out_ready_i (m_ready_i),
    .out_last_o  (m_last_o)
  );

endmodule

//--- dv/fft2d_tb.sv
`timescale 1ns/10ps

module fft2d_tb
  import fft2d_pkg::*;
();

  localparam int NUM_FRAMES      = 3;                        // impulse, constant, random
  localparam int WORDS_PER_FRAME = 2 * FRAME_LEN;            // inputs then expected outputs
  localparam int TOTAL_BEATS     = NUM_FRAMES * FRAME_LEN;   // beats each way
  localparam int RST_CYCLES      = 3;                        // edges with reset low
  localparam int TIMEOUT_CYCLES  = NUM_FRAMES * WORDS_PER_FRAME * 4 + 100;
  localparam int DRAIN_WAIT      = 20;                       // idle cycles to catch extra beats

  logic  clk = 1'b0;
  logic  rst_n_i;
  cplx_t s_data_i;
  logic  s_valid_i;
  logic  s_ready_o;
  cplx_t m_data_o;
  logic  m_valid_o;
  logic  m_ready_i;
  logic  m_last_o;

  logic [31:0] stim_mem [0:NUM_FRAMES*WORDS_PER_FRAME-1];    // whole data file

  int seed = 32'h5498;                                       // shared by gaps and stalls
  int in_sent;                                               // input beats accepted
  int out_cnt;                                               // output beats checked
  int cycle_cnt;                                             // watchdog count

  fft2d_top i_fft2d_top (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .s_data_i  (s_data_i),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .m_data_o  (m_data_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_last_o  (m_last_o)
  );

  always #2 clk = ~clk;                                      // 4 ns period

  // input word n lives in the first half of its frame's block
  function automatic int in_addr(input int n);
    return (n / FRAME_LEN) * WORDS_PER_FRAME + (n % FRAME_LEN);
  endfunction

  // expected word n sits right after the frame's inputs
  function automatic int exp_addr(input int n);
    return (n / FRAME_LEN) * WORDS_PER_FRAME + FRAME_LEN + (n % FRAME_LEN);
  endfunction

  // frame order in the data file
  function automatic string frame_name(input int f);
    if (f == 0)
      return "impulse";
    else if (f == 1)
      return "constant";
    else
      return "random";
  endfunction

  // print the reason and end the run
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected)                                 // x or z counts as a mismatch
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
  endtask

  // stimulus driver with random gaps on s_valid_i and stalls on m_ready_i
  always @(posedge clk)
  begin
    logic [31:0] roll;
    int          nxt;
    if (!rst_n_i)
    begin
      s_valid_i <= 1'b0;
      m_ready_i <= 1'b0;
    end
    else
    begin
      roll = $random(seed);
      nxt  = in_sent;
      if (s_valid_i && s_ready_o)
        nxt = in_sent + 1;                                   // beat just taken
      in_sent <= nxt;

      if (s_valid_i && !s_ready_o)
      begin
        // pending beat keeps its data and valid
      end
      else if (nxt < TOTAL_BEATS && roll[1:0] != 2'b00)
      begin
        s_valid_i <= 1'b1;
        s_data_i  <= stim_mem[in_addr(nxt)];
      end
      else
        s_valid_i <= 1'b0;                                   // gap or all sent

      m_ready_i <= (roll[3:2] != 2'b00);                     // stall about one cycle in four
    end
  end

  // output monitor checks beat by beat in column-major order
  always @(posedge clk)
  begin
    string tag;
    logic  exp_last;
    if (rst_n_i && m_valid_o && m_ready_i)
    begin
      if (out_cnt >= TOTAL_BEATS)
        stop_on_error("output beat arrived after the last expected one");
      else
      begin
        tag = $sformatf("%s frame %0d beat %0d", frame_name(out_cnt / FRAME_LEN),
                        out_cnt / FRAME_LEN, out_cnt % FRAME_LEN);
        exp_last = ((out_cnt % PTS) == PTS - 1);             // end of each column
        check_val({tag, " data"}, stim_mem[exp_addr(out_cnt)], m_data_o);
        check_val({tag, " last"}, {31'd0, exp_last}, {31'd0, m_last_o});
        out_cnt <= out_cnt + 1;
      end
    end
  end

  // watchdog sized from the stimulus length
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      stop_on_error($sformatf("timeout after %0d cycles, %0d of %0d output beats missing",
                              cycle_cnt, TOTAL_BEATS - out_cnt, TOTAL_BEATS));
  end

  initial
  begin
    rst_n_i   = 1'b0;
    s_data_i  = '0;
    s_valid_i = 1'b0;
    m_ready_i = 1'b0;
    in_sent   = 0;
    out_cnt   = 0;
    cycle_cnt = 0;
    $readmemh("dv/fft2d_stimulus.txt", stim_mem);

    // reset held over three rising edges
    repeat (RST_CYCLES - 1)
    begin
      @(negedge clk);
      check_val("reset m_valid_o low", 32'd0, {31'd0, m_valid_o});
      check_val("reset s_ready_o high", 32'd1, {31'd0, s_ready_o});
    end
    @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_val("after reset m_valid_o low", 32'd0, {31'd0, m_valid_o});
    check_val("after reset s_ready_o high", 32'd1, {31'd0, s_ready_o});

    wait (out_cnt == TOTAL_BEATS);                           // monitor saw every beat
    repeat (DRAIN_WAIT) @(posedge clk);                      // any duplicate shows up here
    @(negedge clk);
    if (!m_valid_o)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      stop_on_error("extra output beats after the last frame");
  end

endmodule

//--- dv/fft2d_stimulus.txt
// one 32-bit word per line, im in bits 31:16 and re in bits 15:0
// per frame 16 inputs in row-major order, then 16 expected outputs in column-major order
// frame 0 inputs, impulse of 16 at row 0 column 0
00000010
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
// frame 0 expected, 1 + j0 everywhere
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
00000001
// frame 1 inputs, constant 64 + j32
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
00200040
// frame 1 expected, DC term only
00200040
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
// frame 2 inputs, mixed signs
FFFD000A
00050007
0008FFFE
FFFA0001
0002FFFB
FFF90003
00040009
0000FFFF
00060006
0001FFF8
FFFD0002
00090004
FFFC0000
0002000B
FFFBFFFA
00070003
// frame 2 expected, rows then columns, each scaled by 4 with floor rounding
00000002
FFFF0000
00010000
FFFF0001
FFFFFFFF
FFFF0001
00010002
FFFC0001
FFFFFFFF
FFFF0001
00000002
0002FFFD
FFFF0000
0000FFFE
FFFE0000
FFFEFFFF

//--- compile.f
src/fft2d_pkg.sv
src/fft4_stage.sv
src/corner_turn_buffer.sv
src/fft2d_top.sv
dv/fft2d_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the 2-D FFT testbench with Verilator
set -e

cd "$(dirname "$0")"

# warnings are still printed, they just do not stop the build
verilator --binary --timing -Wno-fatal \
  --top-module fft2d_tb \
  -f compile.f

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/Vfft2d_tb
